// File: source/gmii_udp_pkg.sv
package gmii_udp_pkg;

	typedef logic [7:0]  gmii_byte_t;
	typedef logic [15:0] pix_word_t;
	typedef logic [3:0]  stream_id_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [31:0] crc32_t;
	typedef logic [10:0] sec_count_t;
	typedef logic [15:0] ip_csum_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_SFD,
		ST_HEADER,
		ST_COORD,
		ST_PAYLOAD,
		ST_FCS,
		ST_GAP
	} tx_state_e;

	// Source of the next GMII byte
	typedef enum logic [2:0] {
		SEL_IDLE,
		SEL_PREAMBLE,
		SEL_SFD,
		SEL_HEADER,
		SEL_WORD,
		SEL_FCS
	} byte_sel_e;

	typedef struct packed {
		mac_addr_t src_mac;
		mac_addr_t dst_mac;
		ip_addr_t  src_ip;
		ip_addr_t  dst_ip;
	} frame_addr_t;

	// --------------------
	// Frame layout
	// --------------------
	localparam int PREAMBLE_BYTES = 7;
	localparam int HEADER_BYTES   = 42;
	localparam int COORD_BYTES    = 4;
	localparam int FCS_BYTES      = 4;
	localparam int GAP_CYCLES     = 12;
	localparam int IP_HDR_BYTES   = 20;
	localparam int UDP_HDR_BYTES  = 8;

	localparam gmii_byte_t  PREAMBLE_BYTE = 8'h55;
	localparam gmii_byte_t  SFD_BYTE      = 8'hD5;
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [15:0] IP_VER_TOS    = 16'h4500;
	localparam logic [15:0] IP_IDENT      = 16'h0000;
	localparam logic [15:0] IP_FLAGS_FRAG = 16'h4000;
	localparam logic [7:0]  IP_TTL        = 8'h40;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
	localparam logic [15:0] UDP_SRC_PORT  = 16'd12344;
	localparam logic [15:0] UDP_DST_PORT  = 16'd12345;
	localparam logic [15:0] UDP_CSUM      = 16'h0000;

	// UDP length covers its header, the coordinates and the pixels
	function automatic logic [15:0] udp_len(input int payload_words);
		return 16'(UDP_HDR_BYTES + COORD_BYTES + 2 * payload_words);
	endfunction

	function automatic logic [15:0] ip_total_len(input int payload_words);
		return 16'(IP_HDR_BYTES) + udp_len(payload_words);
	endfunction

	// Stream id offsets on the low address bytes
	function automatic gmii_byte_t add_sid(input gmii_byte_t b, input stream_id_t sid);
		return b + {4'h0, sid};
	endfunction

	function automatic gmii_byte_t sub_sid(input gmii_byte_t b, input stream_id_t sid);
		return b - {4'h0, sid};
	endfunction

endpackage

// File: source/frame_byte_counter.sv
module frame_byte_counter (
	input  logic                     fifo_clk,
	input  logic                     sys_rst,
	input  logic                     load,
	input  gmii_udp_pkg::sec_count_t load_value,
	output gmii_udp_pkg::sec_count_t value,
	output logic                     last
);

	// Loaded with length minus one, parks at zero
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			value <= '0;
		end else if (load) begin
			value <= load_value;
		end else if (value != '0) begin
			value <= value - 1'b1;
		end
	end

	// Final count of the running section
	assign last = (value == '0);

endmodule

// File: source/ipv4_header_checksum.sv
module ipv4_header_checksum #(
	parameter int PAYLOAD_WORDS = 640
) (
	input  logic                      fifo_clk,
	input  logic                      sys_rst,
	input  logic                      start,
	input  gmii_udp_pkg::frame_addr_t addr,
	input  gmii_udp_pkg::stream_id_t  stream_id,
	output gmii_udp_pkg::ip_csum_t    csum
);
	import gmii_udp_pkg::*;

	logic [2:0]  step;
	logic [19:0] acc;
	logic [15:0] word_a;
	logic [15:0] word_b;
	logic [16:0] fold;

	// Two header words per step, checksum field counted as zero
	always_comb begin
		case (step)
			3'd1: begin
				word_a = IP_VER_TOS;
				word_b = ip_total_len(PAYLOAD_WORDS);
			end
			3'd2: begin
				word_a = IP_IDENT;
				word_b = IP_FLAGS_FRAG;
			end
			3'd3: begin
				word_a = {IP_TTL, IP_PROTO_UDP};
				word_b = 16'h0000;
			end
			3'd4: begin
				word_a = addr.src_ip[31:16];
				word_b = {addr.src_ip[15:8], add_sid(addr.src_ip[7:0], stream_id)};
			end
			3'd5: begin
				word_a = addr.dst_ip[31:16];
				word_b = {addr.dst_ip[15:8], sub_sid(addr.dst_ip[7:0], stream_id)};
			end
			default: begin
				word_a = 16'h0000;
				word_b = 16'h0000;
			end
		endcase
	end

	// First carry fold, the second one goes in the final add
	assign fold = {1'b0, acc[15:0]} + {13'h0, acc[19:16]};

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			step <= 3'd0;
		end else if (start) begin
			step <= 3'd1;
			acc  <= '0;
		end else if (step == 3'd6) begin
			csum <= ~(fold[15:0] + {15'h0, fold[16]});
			step <= 3'd0;
		end else if (step != 3'd0) begin
			acc  <= acc + {4'h0, word_a} + {4'h0, word_b};
			step <= step + 3'd1;
		end
	end

endmodule

// File: source/eth_crc32.sv
module eth_crc32 (
	input  logic                     fifo_clk,
	input  logic                     sys_rst,
	input  logic                     init,
	input  logic                     en,
	input  gmii_udp_pkg::gmii_byte_t data,
	output gmii_udp_pkg::crc32_t     crc
);
	import gmii_udp_pkg::*;

	localparam crc32_t CRC_POLY = 32'h04C1_1DB7;

	crc32_t crc_q;
	crc32_t crc_d;

	// One byte, LSB first as it goes on the wire
	function automatic crc32_t crc_step(input crc32_t c, input gmii_byte_t d);
		crc32_t r;
		logic   fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[31] ^ d[i];
			r = {r[30:0], 1'b0};
			if (fb)
				r = r ^ CRC_POLY;
		end
		return r;
	endfunction

	function automatic gmii_byte_t rev8(input gmii_byte_t b);
		gmii_byte_t r;
		for (int i = 0; i < 8; i++)
			r[i] = b[7 - i];
		return r;
	endfunction

	// Includes the byte on data this cycle, so the last byte is in the FCS at once
	assign crc_d = en ? crc_step(crc_q, data) : crc_q;

	always_ff @(posedge fifo_clk) begin
		if (sys_rst || init)
			crc_q <= '1;
		else
			crc_q <= crc_d;
	end

	// FCS bytes in send order, first byte on top
	assign crc = ~{rev8(crc_d[31:24]), rev8(crc_d[23:16]), rev8(crc_d[15:8]), rev8(crc_d[7:0])};

endmodule

// File: source/gmii_tx_fsm.sv
module gmii_tx_fsm #(
	parameter int PAYLOAD_WORDS = 640
) (
	input  logic                     fifo_clk,
	input  logic                     sys_rst,
	input  logic                     line_ready,
	input  logic                     pix_empty,
	input  logic                     cnt_last,
	input  gmii_udp_pkg::sec_count_t cnt_value_now,
	output logic                     cnt_load,
	output gmii_udp_pkg::sec_count_t cnt_value,
	output logic                     ck_start,
	output logic                     crc_init,
	output logic                     crc_en,
	output gmii_udp_pkg::byte_sel_e  byte_sel,
	output gmii_udp_pkg::sec_count_t byte_index,
	output logic                     hi_half,
	output logic                     pix_rd_en
);
	import gmii_udp_pkg::*;

	tx_state_e state;
	tx_state_e state_d;
	logic      start;
	logic      word_sec;

	assign start    = line_ready && !pix_empty;
	assign word_sec = (state == ST_COORD) || (state == ST_PAYLOAD);

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state  <= ST_IDLE;
			crc_en <= 1'b0;
		end else begin
			state  <= state_d;
			// txd lags the selection by one cycle
			crc_en <= (state == ST_HEADER) || word_sec;
		end
	end

	// --------------------
	// Section sequencing
	// --------------------
	always_comb begin
		state_d   = state;
		cnt_load  = 1'b0;
		cnt_value = '0;
		ck_start  = 1'b0;
		byte_sel  = SEL_IDLE;
		case (state)
			ST_IDLE: begin
				if (start) begin
					// First preamble byte goes out right here
					byte_sel  = SEL_PREAMBLE;
					ck_start  = 1'b1;
					cnt_load  = 1'b1;
					cnt_value = sec_count_t'(PREAMBLE_BYTES - 2);
					state_d   = ST_PREAMBLE;
				end
			end
			ST_PREAMBLE: begin
				byte_sel = SEL_PREAMBLE;
				if (cnt_last)
					state_d = ST_SFD;
			end
			ST_SFD: begin
				byte_sel  = SEL_SFD;
				cnt_load  = 1'b1;
				cnt_value = sec_count_t'(HEADER_BYTES - 1);
				state_d   = ST_HEADER;
			end
			ST_HEADER: begin
				byte_sel = SEL_HEADER;
				if (cnt_last) begin
					cnt_load  = 1'b1;
					cnt_value = sec_count_t'(COORD_BYTES - 1);
					state_d   = ST_COORD;
				end
			end
			ST_COORD: begin
				byte_sel = SEL_WORD;
				if (cnt_last) begin
					cnt_load  = 1'b1;
					cnt_value = sec_count_t'(2 * PAYLOAD_WORDS - 1);
					state_d   = ST_PAYLOAD;
				end
			end
			ST_PAYLOAD: begin
				byte_sel = SEL_WORD;
				if (cnt_last) begin
					cnt_load  = 1'b1;
					cnt_value = sec_count_t'(FCS_BYTES - 1);
					state_d   = ST_FCS;
				end
			end
			ST_FCS: begin
				byte_sel = SEL_FCS;
				if (cnt_last) begin
					cnt_load  = 1'b1;
					cnt_value = sec_count_t'(GAP_CYCLES - 1);
					state_d   = ST_GAP;
				end
			end
			default: begin
				if (cnt_last)
					state_d = ST_IDLE;
			end
		endcase
	end

	// Byte position from the start of the section
	always_comb begin
		case (state)
			ST_HEADER: byte_index = sec_count_t'(HEADER_BYTES - 1) - cnt_value_now;
			ST_FCS:    byte_index = sec_count_t'(FCS_BYTES - 1) - cnt_value_now;
			default:   byte_index = cnt_value_now;
		endcase
	end

	// Odd counts are high halves since word sections load an odd value
	assign hi_half   = cnt_value_now[0];
	assign pix_rd_en = word_sec && !cnt_value_now[0];
	assign crc_init  = (state == ST_SFD);

endmodule

// File: source/frame_byte_mux.sv
module frame_byte_mux #(
	parameter int PAYLOAD_WORDS = 640
) (
	input  logic                      fifo_clk,
	input  logic                      sys_rst,
	input  gmii_udp_pkg::byte_sel_e   sel,
	input  gmii_udp_pkg::sec_count_t  index,
	input  logic                      hi_half,
	input  gmii_udp_pkg::frame_addr_t addr,
	input  gmii_udp_pkg::stream_id_t  stream_id,
	input  gmii_udp_pkg::ip_csum_t    csum,
	input  gmii_udp_pkg::crc32_t      crc,
	input  gmii_udp_pkg::pix_word_t   pix_data,
	output logic                      tx_en,
	output gmii_udp_pkg::gmii_byte_t  txd
);
	import gmii_udp_pkg::*;

	localparam int HDR_BITS = HEADER_BYTES * 8;

	logic [HDR_BITS-1:0] hdr;
	logic [8:0]          hdr_lsb;
	gmii_byte_t          hdr_byte;
	gmii_byte_t          fcs_byte;
	gmii_byte_t          byte_d;

	// --------------------
	// Header image
	// --------------------
	// Ethernet, IPv4 and UDP headers, first byte on top
	assign hdr = {
		addr.dst_mac[47:8], sub_sid(addr.dst_mac[7:0], stream_id),
		addr.src_mac[47:8], add_sid(addr.src_mac[7:0], stream_id),
		ETH_TYPE_IPV4,
		IP_VER_TOS,
		ip_total_len(PAYLOAD_WORDS),
		IP_IDENT,
		IP_FLAGS_FRAG,
		IP_TTL,
		IP_PROTO_UDP,
		csum,
		addr.src_ip[31:8], add_sid(addr.src_ip[7:0], stream_id),
		addr.dst_ip[31:8], sub_sid(addr.dst_ip[7:0], stream_id),
		UDP_SRC_PORT,
		UDP_DST_PORT,
		udp_len(PAYLOAD_WORDS),
		UDP_CSUM
	};

	assign hdr_lsb  = 9'((HEADER_BYTES - 1 - int'(index)) * 8);
	assign hdr_byte = hdr[hdr_lsb +: 8];

	always_comb begin
		case (index[1:0])
			2'd0:    fcs_byte = crc[31:24];
			2'd1:    fcs_byte = crc[23:16];
			2'd2:    fcs_byte = crc[15:8];
			default: fcs_byte = crc[7:0];
		endcase
	end

	always_comb begin
		case (sel)
			SEL_PREAMBLE: byte_d = PREAMBLE_BYTE;
			SEL_SFD:      byte_d = SFD_BYTE;
			SEL_HEADER:   byte_d = hdr_byte;
			SEL_WORD:     byte_d = hi_half ? pix_data[15:8] : pix_data[7:0];
			SEL_FCS:      byte_d = fcs_byte;
			default:      byte_d = 8'h00;
		endcase
	end

	// GMII output register
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			tx_en <= 1'b0;
			txd   <= 8'h00;
		end else begin
			tx_en <= (sel != SEL_IDLE);
			txd   <= byte_d;
		end
	end

endmodule

// File: source/gmii_udp_tx.sv
module gmii_udp_tx #(
	parameter int                      PAYLOAD_WORDS = 640,
	parameter gmii_udp_pkg::mac_addr_t SRC_MAC       = 48'h00_23_45_67_89_01,
	parameter gmii_udp_pkg::mac_addr_t DST_MAC       = 48'h00_23_45_67_89_02,
	parameter gmii_udp_pkg::ip_addr_t  SRC_IP        = {8'd192, 8'd168, 8'd0, 8'd1},
	parameter gmii_udp_pkg::ip_addr_t  DST_IP        = {8'd192, 8'd168, 8'd0, 8'd2}
) (
	input  logic                     fifo_clk,
	input  logic                     sys_rst,
	input  gmii_udp_pkg::pix_word_t  pix_data,
	input  logic                     pix_empty,
	input  logic                     line_ready,
	output logic                     pix_rd_en,
	input  gmii_udp_pkg::stream_id_t stream_id,
	output logic                     tx_en,
	output gmii_udp_pkg::gmii_byte_t txd
);
	import gmii_udp_pkg::*;

	frame_addr_t frame_addr;
	stream_id_t  stream_id_q;
	sec_count_t  cnt_value;
	sec_count_t  cnt_value_now;
	sec_count_t  byte_index;
	byte_sel_e   byte_sel;
	ip_csum_t    ip_csum;
	crc32_t      crc;
	logic        cnt_load;
	logic        cnt_last;
	logic        ck_start;
	logic        crc_init;
	logic        crc_en;
	logic        hi_half;

	assign frame_addr = '{src_mac: SRC_MAC, dst_mac: DST_MAC, src_ip: SRC_IP, dst_ip: DST_IP};

	// Stream id held for the whole frame
	always_ff @(posedge fifo_clk) begin
		if (sys_rst)
			stream_id_q <= '0;
		else if (ck_start)
			stream_id_q <= stream_id;
	end

	gmii_tx_fsm #(
		.PAYLOAD_WORDS (PAYLOAD_WORDS)
	) u_fsm (
		.fifo_clk      (fifo_clk),
		.sys_rst       (sys_rst),
		.line_ready    (line_ready),
		.pix_empty     (pix_empty),
		.cnt_last      (cnt_last),
		.cnt_value_now (cnt_value_now),
		.cnt_load      (cnt_load),
		.cnt_value     (cnt_value),
		.ck_start      (ck_start),
		.crc_init      (crc_init),
		.crc_en        (crc_en),
		.byte_sel      (byte_sel),
		.byte_index    (byte_index),
		.hi_half       (hi_half),
		.pix_rd_en     (pix_rd_en)
	);

	frame_byte_counter u_counter (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.load       (cnt_load),
		.load_value (cnt_value),
		.value      (cnt_value_now),
		.last       (cnt_last)
	);

	ipv4_header_checksum #(
		.PAYLOAD_WORDS (PAYLOAD_WORDS)
	) u_csum (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.start     (ck_start),
		.addr      (frame_addr),
		.stream_id (stream_id_q),
		.csum      (ip_csum)
	);

	eth_crc32 u_crc (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.init     (crc_init),
		.en       (crc_en),
		.data     (txd),
		.crc      (crc)
	);

	frame_byte_mux #(
		.PAYLOAD_WORDS (PAYLOAD_WORDS)
	) u_mux (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.sel       (byte_sel),
		.index     (byte_index),
		.hi_half   (hi_half),
		.addr      (frame_addr),
		.stream_id (stream_id_q),
		.csum      (ip_csum),
		.crc       (crc),
		.pix_data  (pix_data),
		.tx_en     (tx_en),
		.txd       (txd)
	);

endmodule

// File: verif/gmii_udp_tx_assert.sv
module gmii_udp_tx_assert #(
	parameter int PAYLOAD_WORDS = 640
) (
	input logic fifo_clk,
	input logic sys_rst,
	input logic pix_rd_en,
	input logic pix_empty,
	input logic tx_en
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_BYTES = 8 + 42 + 4 + 2 * PAYLOAD_WORDS + 4;
	localparam int MIN_GAP     = 12;

	int high_run;
	int low_run;

	// Run lengths of tx_en, low run saturates at the gap length
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			high_run <= 0;
			low_run  <= MIN_GAP;
		end else if (tx_en) begin
			high_run <= high_run + 1;
			low_run  <= 0;
		end else begin
			high_run <= 0;
			if (low_run < MIN_GAP)
				low_run <= low_run + 1;
		end
	end

	no_pop_when_empty: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		pix_rd_en |-> !pix_empty)
		else $error("FIFO popped while empty");

	drop_after_fcs: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$fell(tx_en) |-> high_run == FRAME_BYTES)
		else $error("tx_en dropped after %0d bytes", high_run);

	gap_after_frame: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$rose(tx_en) |-> low_run >= MIN_GAP)
		else $error("inter-frame gap of only %0d cycles", low_run);

endmodule

bind gmii_udp_tx gmii_udp_tx_assert #(
	.PAYLOAD_WORDS (PAYLOAD_WORDS)
) u_assert (
	.fifo_clk  (fifo_clk),
	.sys_rst   (sys_rst),
	.pix_rd_en (pix_rd_en),
	.pix_empty (pix_empty),
	.tx_en     (tx_en)
);

// File: verif/gmii_udp_tx_tb.sv
module gmii_udp_tx_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import gmii_udp_pkg::*;

	localparam int          PAYLOAD_WORDS  = 16;
	localparam int          LINE_WORDS     = 2 + PAYLOAD_WORDS;
	localparam int          FRAME_BYTES    = 8 + 42 + 4 + 2 * PAYLOAD_WORDS + 4;
	localparam int          GAP_MIN        = 12;
	localparam int          NUM_FRAMES     = 4;
	localparam int          GATE_CYCLES    = 40;
	localparam int          RESET_CYCLES   = 4;
	localparam int          TIMEOUT_CYCLES = NUM_FRAMES * (FRAME_BYTES + GAP_MIN + 20)
		+ GATE_CYCLES + RESET_CYCLES + 4;
	localparam mac_addr_t   SRC_MAC        = 48'h02_10_20_30_40_50;
	localparam mac_addr_t   DST_MAC        = 48'h02_10_20_30_40_A0;
	localparam ip_addr_t    SRC_IP         = {8'd10, 8'd1, 8'd0, 8'd20};
	localparam ip_addr_t    DST_IP         = {8'd10, 8'd1, 8'd0, 8'd80};

	typedef gmii_byte_t byte_q_t[$];
	typedef pix_word_t  word_q_t[$];

	logic       fifo_clk;
	logic       sys_rst;
	pix_word_t  pix_data;
	logic       pix_empty;
	logic       line_ready;
	logic       pix_rd_en;
	stream_id_t stream_id;
	logic       tx_en;
	gmii_byte_t txd;

	// FIFO model and expected lines
	pix_word_t  fifo_q[$];
	stream_id_t sid_q[$];
	pix_word_t  exp_words[$];
	stream_id_t exp_sid[$];
	int         pops_in_line;
	int         line_no;
	logic       ready_en;
	logic       pop_req;

	// Capture state
	byte_q_t    cur_frame;
	byte_q_t    done_frame;
	int         frame_pops;
	int         done_pops;
	int         frames_started;
	int         frames_captured;
	int         frames_checked;
	int         low_run;
	logic       prev_en;
	logic       run_done;

	int         errors;
	int         errs_mark;
	int         tests_run;
	int         tests_failed;

	gmii_udp_tx #(
		.PAYLOAD_WORDS (PAYLOAD_WORDS),
		.SRC_MAC       (SRC_MAC),
		.DST_MAC       (DST_MAC),
		.SRC_IP        (SRC_IP),
		.DST_IP        (DST_IP)
	) dut (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.pix_data   (pix_data),
		.pix_empty  (pix_empty),
		.line_ready (line_ready),
		.pix_rd_en  (pix_rd_en),
		.stream_id  (stream_id),
		.tx_en      (tx_en),
		.txd        (txd)
	);

	always #2 fifo_clk = ~fifo_clk;

	// --------------------
	// Reference model
	// --------------------
	function automatic crc32_t crc32_ref(input byte_q_t q, input int first);
		crc32_t c;
		c = '1;
		for (int i = first; i < q.size(); i++) begin
			c = c ^ {24'h0, q[i]};
			for (int b = 0; b < 8; b++)
				c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
		end
		return ~c;
	endfunction

	// One's-complement sum of the 20 IP header bytes starting at pos
	function automatic ip_csum_t ones_sum(input byte_q_t q, input int pos);
		logic [31:0] sum;
		sum = '0;
		for (int i = 0; i < 10; i++)
			sum = sum + {16'h0, q[pos + 2 * i], q[pos + 2 * i + 1]};
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		return sum[15:0];
	endfunction

	function automatic byte_q_t ref_frame(input word_q_t words, input stream_id_t sid);
		byte_q_t     q;
		logic [15:0] hw [21];
		mac_addr_t   dmac;
		mac_addr_t   smac;
		ip_addr_t    sip;
		ip_addr_t    dip;
		logic [15:0] udp_l;
		crc32_t      c;
		dmac       = DST_MAC;
		smac       = SRC_MAC;
		sip        = SRC_IP;
		dip        = DST_IP;
		dmac[7:0]  = DST_MAC[7:0] - {4'h0, sid};
		smac[7:0]  = SRC_MAC[7:0] + {4'h0, sid};
		sip[7:0]   = SRC_IP[7:0] + {4'h0, sid};
		dip[7:0]   = DST_IP[7:0] - {4'h0, sid};
		udp_l      = 16'(8 + 4 + 2 * PAYLOAD_WORDS);
		hw = '{dmac[47:32], dmac[31:16], dmac[15:0], smac[47:32], smac[31:16], smac[15:0],
			16'h0800, 16'h4500, 16'(20) + udp_l, 16'h0000, 16'h4000, 16'h4011, 16'h0000,
			sip[31:16], sip[15:0], dip[31:16], dip[15:0],
			16'd12344, 16'd12345, udp_l, 16'h0000};
		for (int i = 0; i < 7; i++)
			q.push_back(8'h55);
		q.push_back(8'hD5);
		for (int i = 0; i < 21; i++) begin
			q.push_back(hw[i][15:8]);
			q.push_back(hw[i][7:0]);
		end
		// Software header checksum into bytes 32 and 33
		hw[12] = ~ones_sum(q, 22);
		q[32]  = hw[12][15:8];
		q[33]  = hw[12][7:0];
		for (int i = 0; i < words.size(); i++) begin
			q.push_back(words[i][15:8]);
			q.push_back(words[i][7:0]);
		end
		c = crc32_ref(q, 8);
		q.push_back(c[7:0]);
		q.push_back(c[15:8]);
		q.push_back(c[23:16]);
		q.push_back(c[31:24]);
		return q;
	endfunction

	// --------------------
	// Compare tasks
	// --------------------
	task automatic check_byte(input string test, input int pos, input gmii_byte_t exp,
		input gmii_byte_t act);
		if (exp !== act) begin
			errors++;
			$display("** Error %s byte %0d: expected %02h, actual %02h", test, pos, exp, act);
		end
	endtask

	task automatic check_crc(input string test, input crc32_t exp, input crc32_t act);
		if (exp !== act) begin
			errors++;
			$display("** Error %s fcs: expected %08h, actual %08h", test, exp, act);
		end
	endtask

	task automatic check_csum(input string test, input ip_csum_t exp, input ip_csum_t act);
		if (exp !== act) begin
			errors++;
			$display("** Error %s ip header sum: expected %04h, actual %04h", test, exp, act);
		end
	endtask

	task automatic report_test(input string test);
		tests_run++;
		if (errors == errs_mark) begin
			$display("PASS %s", test);
		end else begin
			tests_failed++;
			$display("FAIL %s: %0d errors", test, errors - errs_mark);
		end
		errs_mark = errors;
	endtask

	task automatic check_frame(input int f);
		byte_q_t    exp;
		word_q_t    words;
		stream_id_t sid;
		string      test;
		int         n;
		sid  = exp_sid[f];
		test = $sformatf("frame%0d_sid%0d", f, sid);
		for (int i = 0; i < LINE_WORDS; i++)
			words.push_back(exp_words[f * LINE_WORDS + i]);
		exp = ref_frame(words, sid);
		n   = done_frame.size();
		if (n != exp.size()) begin
			errors++;
			$display("** Error %s length: expected %0d, actual %0d", test, exp.size(), n);
		end else begin
			for (int i = 0; i < n - 4; i++)
				check_byte(test, i, exp[i], done_frame[i]);
			check_csum(test, 16'hFFFF, ones_sum(done_frame, 22));
			check_crc(test, {exp[n-4], exp[n-3], exp[n-2], exp[n-1]},
				{done_frame[n-4], done_frame[n-3], done_frame[n-2], done_frame[n-1]});
		end
		if (done_pops != LINE_WORDS) begin
			errors++;
			$display("** Error %s pops: expected %0d, actual %0d", test, LINE_WORDS, done_pops);
		end
		report_test(test);
	endtask

	// Coordinate words first, then random pixel pairs
	task automatic push_line(input stream_id_t sid);
		pix_word_t w;
		for (int i = 0; i < LINE_WORDS; i++) begin
			if (i == 0)
				w = pix_word_t'(line_no);
			else if (i == 1)
				w = 16'h0000;
			else
				w = pix_word_t'($urandom);
			fifo_q.push_back(w);
			exp_words.push_back(w);
		end
		sid_q.push_back(sid);
		exp_sid.push_back(sid);
		line_no++;
	endtask

	// --------------------
	// Show-ahead FIFO model
	// --------------------
	always @(posedge fifo_clk) begin
		#1;
		if (pop_req) begin
			if (fifo_q.size() == 0) begin
				errors++;
				$display("DUT popped the FIFO model while it was empty");
			end else begin
				void'(fifo_q.pop_front());
				pops_in_line++;
				if (pops_in_line == LINE_WORDS) begin
					void'(sid_q.pop_front());
					pops_in_line = 0;
				end
			end
		end
		pix_empty  = (fifo_q.size() == 0);
		pix_data   = pix_empty ? 16'h0000 : fifo_q[0];
		stream_id  = (sid_q.size() == 0) ? 4'h0 : sid_q[0];
		line_ready = ready_en && (fifo_q.size() >= LINE_WORDS);
	end

	// Capture on the falling edge where outputs are settled
	always @(negedge fifo_clk) begin
		pop_req = pix_rd_en && !sys_rst;
		if (!sys_rst) begin
			if (pix_rd_en)
				frame_pops++;
			if (tx_en) begin
				if (!prev_en) begin
					if (frames_started > 0 && low_run < GAP_MIN) begin
						errors++;
						$display("frame %0d started after only %0d idle cycles",
							frames_started, low_run);
					end
					frames_started++;
					cur_frame.delete();
				end
				cur_frame.push_back(txd);
				low_run = 0;
			end else begin
				if (prev_en) begin
					done_frame = cur_frame;
					done_pops  = frame_pops;
					frame_pops = 0;
					frames_captured++;
				end
				low_run++;
			end
			prev_en = tx_en;
		end
	end

	initial begin
		for (int f = 0; f < NUM_FRAMES; f++) begin
			wait (frames_captured > f);
			check_frame(f);
			frames_checked++;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (!run_done && cycles < TIMEOUT_CYCLES) begin
			@(posedge fifo_clk);
			cycles++;
		end
		if (!run_done) begin
			$display("timeout after %0d cycles with %0d of %0d frames checked",
				cycles, frames_checked, NUM_FRAMES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h3ffb_4e34));
		fifo_clk        = 1'b0;
		sys_rst         = 1'b1;
		pix_data        = '0;
		pix_empty       = 1'b1;
		line_ready      = 1'b0;
		stream_id       = '0;
		ready_en        = 1'b0;
		pop_req         = 1'b0;
		prev_en         = 1'b0;
		run_done        = 1'b0;
		pops_in_line    = 0;
		line_no         = 0;
		frame_pops      = 0;
		done_pops       = 0;
		frames_started  = 0;
		frames_captured = 0;
		frames_checked  = 0;
		low_run         = 0;
		errors          = 0;
		errs_mark       = 0;
		tests_run       = 0;
		tests_failed    = 0;
		repeat (RESET_CYCLES) @(posedge fifo_clk);
		#1 sys_rst = 1'b0;

		// A full line but line_ready held low
		@(negedge fifo_clk);
		push_line(4'd0);
		repeat (GATE_CYCLES) @(negedge fifo_clk);
		if (frames_started != 0) begin
			errors++;
			$display("a frame started while line_ready was low");
		end
		report_test("no_start_without_line_ready");

		// Remaining lines queued so the frames run back to back
		push_line(4'd3);
		push_line(4'd9);
		push_line(4'd6);
		ready_en = 1'b1;
		wait (frames_checked == NUM_FRAMES);
		run_done = 1'b1;
		repeat (2) @(negedge fifo_clk);

		$display("tests: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: gmii_udp_tx.f
source/gmii_udp_pkg.sv
source/frame_byte_counter.sv
source/ipv4_header_checksum.sv
source/eth_crc32.sv
source/gmii_tx_fsm.sv
source/frame_byte_mux.sv
source/gmii_udp_tx.sv
verif/gmii_udp_tx_assert.sv
verif/gmii_udp_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run the GMII UDP transmitter testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module gmii_udp_tx_tb -f gmii_udp_tx.f || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vgmii_udp_tx_tb)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "TEST PASSED" && echo "simulation: pass" \
	|| { echo "simulation: fail"; exit 1; }
